// File: rtl/rs_pkg.sv
/*
 * Reservation station shared types for physical tags, functional-unit
 * classes, the stored micro-op, the issue packet and side-band levels
 */
package rs_pkg;

	// ------------------------------------------------------------------------
	// Tags and classes
	// ------------------------------------------------------------------------

	// 64 physical registers
	localparam int TAG_BITS = 6;

	typedef logic [TAG_BITS-1:0] phys_tag_t;

	// Class value is also the issue port index
	typedef enum logic [2:0] {
		FU_ALU  = 3'd0,
		FU_LD   = 3'd1,
		FU_ST   = 3'd2,
		FU_MULT = 3'd3,
		FU_BR   = 3'd4
	} fu_class_t;

	localparam int NUM_FU = 5;

	// ------------------------------------------------------------------------
	// Payloads
	// ------------------------------------------------------------------------

	// One waiting micro-op of 32 bits whose valid doubles as the busy bit
	typedef struct packed {
		logic      valid;
		fu_class_t fu;
		phys_tag_t dest;
		phys_tag_t src1;
		logic      src1_ready;
		phys_tag_t src2;
		logic      src2_ready;
		logic [7:0] opcode;
	} micro_op_t;

	// What a functional unit sees (18 bits)
	typedef struct packed {
		logic      valid;
		fu_class_t fu;
		phys_tag_t dest;
		logic [7:0] opcode;
	} issue_pkt_t;

	// Common data bus broadcast
	typedef struct packed {
		logic      valid;
		phys_tag_t tag;
	} cdb_t;

	// Load/store queue back-pressure levels
	typedef struct packed {
		logic ld_full;
		logic st_full;
	} lsq_block_t;

endpackage

// File: rtl/tag_cam.sv
/*
 * Wakeup CAM that compares the common data bus tag against both
 * source tags of every busy entry
 */
`timescale 1ns/1ns

module tag_cam #(
	parameter int RS_SIZE = 12
) (
	input  rs_pkg::micro_op_t  entries [RS_SIZE],
	input  rs_pkg::cdb_t       cdb,
	output logic [RS_SIZE-1:0] src1_hit,
	output logic [RS_SIZE-1:0] src2_hit
);

	// Two compare ports per entry working in parallel
	always_comb begin
		for (int i = 0; i < RS_SIZE; i++) begin
			// Idle entries and an idle bus never hit
			src1_hit[i] = cdb.valid & entries[i].valid &
				(entries[i].src1 == cdb.tag);
			src2_hit[i] = cdb.valid & entries[i].valid &
				(entries[i].src2 == cdb.tag);
		end
	end

endmodule

// File: rtl/prio_select.sv
/*
 * Two-level priority selector that grants the highest-numbered
 * request using groups of four
 */
`timescale 1ns/1ns

module prio_select #(
	parameter int WIDTH = 12
) (
	input  logic [WIDTH-1:0] req,
	output logic [WIDTH-1:0] gnt,
	output logic             any
);

	localparam int GROUPS = (WIDTH + 3) / 4;
	localparam int PAD_W  = GROUPS * 4;

	logic [PAD_W-1:0]  req_pad;
	logic [PAD_W-1:0]  gnt_pad;
	logic [GROUPS-1:0] group_req;
	logic [GROUPS-1:0] group_gnt;

	// Zero-fill up to a whole number of groups
	assign req_pad = PAD_W'(req);

	// ------------------------------------------------------------------------
	// Top level picks the highest group that has a request
	// ------------------------------------------------------------------------
	always_comb begin
		group_gnt = '0;
		for (int g = 0; g < GROUPS; g++) begin
			group_req[g] = |req_pad[4*g +: 4];
			// Later (higher) groups overwrite earlier ones
			if (group_req[g]) begin
				group_gnt = '0;
				group_gnt[g] = 1'b1;
			end
		end
	end

	// Bottom level picks the highest request inside the chosen group
	for (genvar g = 0; g < GROUPS; g++) begin : g_group
		logic [3:0] r;
		assign r = req_pad[4*g +: 4];
		assign gnt_pad[4*g+3] = group_gnt[g] & r[3];
		assign gnt_pad[4*g+2] = group_gnt[g] & r[2] & ~r[3];
		assign gnt_pad[4*g+1] = group_gnt[g] & r[1] & ~|r[3:2];
		assign gnt_pad[4*g]   = group_gnt[g] & r[0] & ~|r[3:1];
	end

	assign gnt = gnt_pad[WIDTH-1:0];
	assign any = |group_req;

endmodule

// File: rtl/rs_entry_table.sv
/*
 * Reservation station entry storage with allocation of the lowest free
 * entry, wakeup of source operands, release on issue, busy count and full
 */
`timescale 1ns/1ns

module rs_entry_table #(
	parameter int RS_SIZE = 12
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               enable,
	input  logic               dispatch,
	input  rs_pkg::micro_op_t  dispatch_op,
	input  logic [RS_SIZE-1:0] src1_hit,
	input  logic [RS_SIZE-1:0] src2_hit,
	input  logic [RS_SIZE-1:0] issue_gnt,
	output rs_pkg::micro_op_t  entries [RS_SIZE],
	output rs_pkg::micro_op_t  woken [RS_SIZE],
	output logic               rs_full
);

	import rs_pkg::*;

	// Count must reach RS_SIZE itself
	localparam int CNT_W = $clog2(RS_SIZE + 1);

	micro_op_t          entries_next [RS_SIZE];
	logic [RS_SIZE-1:0] free_rev;
	logic [RS_SIZE-1:0] alloc_rev_gnt;
	logic [RS_SIZE-1:0] alloc_gnt;
	logic               alloc_any;
	logic               accept;
	logic [CNT_W-1:0]   busy_cnt;
	logic [CNT_W-1:0]   busy_cnt_next;
	logic [CNT_W-1:0]   issued_cnt;

	// ------------------------------------------------------------------------
	// Wakeup view
	// ------------------------------------------------------------------------

	// Stored entry plus this cycle's bus hits for selection
	always_comb begin
		for (int i = 0; i < RS_SIZE; i++) begin
			woken[i] = entries[i];
			woken[i].src1_ready = entries[i].src1_ready | src1_hit[i];
			woken[i].src2_ready = entries[i].src2_ready | src2_hit[i];
		end
	end

	// ------------------------------------------------------------------------
	// Allocation
	// ------------------------------------------------------------------------

	// Selector favours high indices, so reverse to get the lowest free slot
	// An entry issuing now still counts as busy here
	always_comb begin
		for (int i = 0; i < RS_SIZE; i++) begin
			free_rev[i] = ~entries[RS_SIZE-1-i].valid;
		end
	end

	prio_select #(
		.WIDTH(RS_SIZE)
	) alloc_sel (
		.req(free_rev),
		.gnt(alloc_rev_gnt),
		.any(alloc_any)
	);

	always_comb begin
		for (int i = 0; i < RS_SIZE; i++) begin
			alloc_gnt[i] = alloc_rev_gnt[RS_SIZE-1-i];
		end
	end

	// Full station or frozen pipe drops the dispatch
	assign accept = dispatch & dispatch_op.valid & enable & ~rs_full & alloc_any;

	// ------------------------------------------------------------------------
	// Next state of each entry
	// ------------------------------------------------------------------------
	always_comb begin
		for (int i = 0; i < RS_SIZE; i++) begin
			entries_next[i] = woken[i];
			// Granted entries leave at the edge their packet appears
			if (issue_gnt[i]) begin
				entries_next[i].valid = 1'b0;
			end
			if (accept & alloc_gnt[i]) begin
				entries_next[i] = dispatch_op;
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < RS_SIZE; i++) begin
			entries[i] <= entries_next[i];
			if (reset) begin
				entries[i].valid <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Busy count and full flag
	// ------------------------------------------------------------------------

	// Up to one entry per class leaves each cycle
	always_comb begin
		issued_cnt = '0;
		for (int i = 0; i < RS_SIZE; i++) begin
			issued_cnt = issued_cnt + CNT_W'(issue_gnt[i]);
		end
	end

	assign busy_cnt_next = busy_cnt - issued_cnt + CNT_W'(accept);

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_cnt <= '0;
			rs_full  <= 1'b0;
		end else begin
			busy_cnt <= busy_cnt_next;
			// Full tracks the count that the entries hold after this edge
			rs_full  <= (busy_cnt_next == CNT_W'(RS_SIZE));
		end
	end

endmodule

// File: rtl/issue_select.sv
/*
 * Issue selection of one ready entry per functional-unit class with
 * load/store back-pressure, registering the issue packets and count
 */
`timescale 1ns/1ns

module issue_select #(
	parameter int RS_SIZE = 12
) (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic                                  enable,
	input  rs_pkg::micro_op_t                     woken [RS_SIZE],
	input  rs_pkg::lsq_block_t                    lsq_block,
	output logic [RS_SIZE-1:0]                    issue_gnt,
	output rs_pkg::issue_pkt_t                    issue_out [rs_pkg::NUM_FU],
	output logic [$clog2(rs_pkg::NUM_FU + 1)-1:0] issue_count
);

	import rs_pkg::*;

	localparam int ICNT_W = $clog2(NUM_FU + 1);

	logic [RS_SIZE-1:0] class_req [NUM_FU];
	logic [RS_SIZE-1:0] class_gnt [NUM_FU];
	logic [NUM_FU-1:0]  class_any;
	issue_pkt_t         pkt_next [NUM_FU];
	logic [ICNT_W-1:0]  count_next;

	// ------------------------------------------------------------------------
	// Request masks
	// ------------------------------------------------------------------------
	always_comb begin
		for (int c = 0; c < NUM_FU; c++) begin
			for (int i = 0; i < RS_SIZE; i++) begin
				// Busy, both operands ready, right class
				class_req[c][i] = enable & woken[i].valid & woken[i].src1_ready &
					woken[i].src2_ready & (woken[i].fu == fu_class_t'(c));
			end
		end
		// Memory ops wait while their queue is full
		if (lsq_block.ld_full) begin
			class_req[FU_LD] = '0;
		end
		if (lsq_block.st_full) begin
			class_req[FU_ST] = '0;
		end
	end

	// One selector per class
	for (genvar c = 0; c < NUM_FU; c++) begin : g_class
		prio_select #(
			.WIDTH(RS_SIZE)
		) sel (
			.req(class_req[c]),
			.gnt(class_gnt[c]),
			.any(class_any[c])
		);
	end

	// ------------------------------------------------------------------------
	// Packets and grant vector
	// ------------------------------------------------------------------------
	always_comb begin
		issue_gnt  = '0;
		count_next = '0;
		for (int c = 0; c < NUM_FU; c++) begin
			// Idle port carries an all-zero packet
			pkt_next[c] = '0;
			pkt_next[c].valid = class_any[c];
			issue_gnt = issue_gnt | class_gnt[c];
			count_next = count_next + ICNT_W'(class_any[c]);
			for (int i = 0; i < RS_SIZE; i++) begin
				if (class_gnt[c][i]) begin
					pkt_next[c].fu     = woken[i].fu;
					pkt_next[c].dest   = woken[i].dest;
					pkt_next[c].opcode = woken[i].opcode;
				end
			end
		end
	end

	// Packets live for exactly one cycle
	always_ff @(posedge clock) begin
		for (int c = 0; c < NUM_FU; c++) begin
			issue_out[c] <= pkt_next[c];
			if (reset) begin
				issue_out[c].valid <= 1'b0;
			end
		end
		if (reset) begin
			issue_count <= '0;
		end else begin
			issue_count <= count_next;
		end
	end

endmodule

// File: rtl/rs_top.sv
/*
 * Reservation station top level joining the entry table, the wakeup
 * CAM and per-class issue selection
 */
`timescale 1ns/1ns

module rs_top #(
	parameter int RS_SIZE = 12
) (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic                                  enable,
	input  logic                                  dispatch,
	input  rs_pkg::micro_op_t                     dispatch_op,
	input  rs_pkg::cdb_t                          cdb,
	input  rs_pkg::lsq_block_t                    lsq_block,
	output rs_pkg::issue_pkt_t                    issue_out [rs_pkg::NUM_FU],
	output logic [$clog2(rs_pkg::NUM_FU + 1)-1:0] issue_count,
	output logic                                  rs_full
);

	import rs_pkg::*;

	micro_op_t          entries [RS_SIZE];
	micro_op_t          woken [RS_SIZE];
	logic [RS_SIZE-1:0] src1_hit;
	logic [RS_SIZE-1:0] src2_hit;
	logic [RS_SIZE-1:0] issue_gnt;

	// Storage, allocation and release
	rs_entry_table #(
		.RS_SIZE(RS_SIZE)
	) table0 (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.dispatch(dispatch),
		.dispatch_op(dispatch_op),
		.src1_hit(src1_hit),
		.src2_hit(src2_hit),
		.issue_gnt(issue_gnt),
		.entries(entries),
		.woken(woken),
		.rs_full(rs_full)
	);

	// Bus snoop keeps running while frozen
	tag_cam #(
		.RS_SIZE(RS_SIZE)
	) cam0 (
		.entries(entries),
		.cdb(cdb),
		.src1_hit(src1_hit),
		.src2_hit(src2_hit)
	);

	issue_select #(
		.RS_SIZE(RS_SIZE)
	) issue0 (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.woken(woken),
		.lsq_block(lsq_block),
		.issue_gnt(issue_gnt),
		.issue_out(issue_out),
		.issue_count(issue_count)
	);

endmodule

// File: testbench/rs_tb.sv
/*
 * Reservation station testbench driving a table of dispatch, bus and
 * back-pressure stimulus and checking issue ports, count and full flag
 */
`timescale 1ns/1ns

module rs_tb;

	import rs_pkg::*;

	localparam int RS_SIZE      = 12;
	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_ROWS     = 44;
	localparam int ICNT_W       = $clog2(NUM_FU + 1);
	// Covers reset, every row, the drain cycle and some slack
	localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_ROWS + 2) * CLK_PERIOD + 100;

	logic              clock = 1'b0;
	logic              reset;
	logic              enable;
	logic              dispatch;
	micro_op_t         dispatch_op;
	cdb_t              cdb;
	lsq_block_t        lsq_block;
	issue_pkt_t        issue_out [NUM_FU];
	logic [ICNT_W-1:0] issue_count;
	logic              rs_full;

	// Stimulus and expected results for each cycle
	logic       row_disp [NUM_ROWS];
	micro_op_t  row_op [NUM_ROWS];
	cdb_t       row_cdb [NUM_ROWS];
	lsq_block_t row_lsq [NUM_ROWS];
	logic       row_en [NUM_ROWS];
	// Row whose micro-op each class port carries or -1 for an idle port
	int         row_src [NUM_ROWS][NUM_FU];
	logic       row_full [NUM_ROWS];
	int         row_idx = 0;
	logic [31:0] lfsr_state = 32'd70832;

	rs_top #(
		.RS_SIZE(RS_SIZE)
	) dut0 (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.dispatch(dispatch),
		.dispatch_op(dispatch_op),
		.cdb(cdb),
		.lsq_block(lsq_block),
		.issue_out(issue_out),
		.issue_count(issue_count),
		.rs_full(rs_full)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// ------------------------------------------------------------------------
	// Opcode source and table building
	// ------------------------------------------------------------------------

	// Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out) begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return out;
	endfunction

	function automatic logic [7:0] random_opcode();
		logic [7:0] value;
		value = '0;
		for (int b = 0; b < 8; b++) begin
			value = {value[6:0], lfsr_bit()};
		end
		return value;
	endfunction

	task automatic add_row(
		input logic disp, input fu_class_t fu, input int dest,
		input int s1, input logic r1, input int s2, input logic r2,
		input logic cdb_v, input int cdb_tag, input logic ld_full, input logic st_full,
		input logic en, input int alu_row, input int ld_row, input int st_row,
		input int mult_row, input int br_row, input logic full
	);
		micro_op_t op;
		op = '0;
		op.valid = disp;
		op.fu = fu;
		op.dest = phys_tag_t'(dest);
		op.src1 = phys_tag_t'(s1);
		op.src1_ready = r1;
		op.src2 = phys_tag_t'(s2);
		op.src2_ready = r2;
		op.opcode = random_opcode();
		if (row_idx < NUM_ROWS) begin
			row_disp[row_idx] = disp;
			row_op[row_idx] = op;
			row_cdb[row_idx] = {cdb_v, phys_tag_t'(cdb_tag)};
			row_lsq[row_idx] = {ld_full, st_full};
			row_en[row_idx] = en;
			row_src[row_idx] = '{alu_row, ld_row, st_row, mult_row, br_row};
			row_full[row_idx] = full;
		end
		row_idx++;
	endtask

	// ------------------------------------------------------------------------
	// Reference results and checks
	// ------------------------------------------------------------------------

	// Packet a class port carries for the micro-op of a given row
	function automatic issue_pkt_t expected_pkt(input int src_row);
		issue_pkt_t pkt;
		pkt = '0;
		if (src_row >= 0) begin
			pkt.valid = 1'b1;
			pkt.fu = row_op[src_row].fu;
			pkt.dest = row_op[src_row].dest;
			pkt.opcode = row_op[src_row].opcode;
		end
		return pkt;
	endfunction

	task automatic stop_run(input string what);
		$display("sim failed");
		$fatal(1, "%s", what);
	endtask

	task automatic check_issue(input string name, input issue_pkt_t got, input issue_pkt_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
			stop_run("issue packet mismatch");
		end
	endtask

	task automatic check_count(input string name, input logic [ICNT_W-1:0] got,
			input logic [ICNT_W-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
			stop_run("issue count mismatch");
		end
	endtask

	task automatic check_full(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
			stop_run("full flag mismatch");
		end
	endtask

	// Count is the number of busy ports in the row
	task automatic check_row(input int k);
		int n_valid;
		n_valid = 0;
		for (int c = 0; c < NUM_FU; c++) begin
			check_issue($sformatf("issue_out[%0d] row %0d", c, k), issue_out[c],
				expected_pkt(row_src[k][c]));
			if (row_src[k][c] >= 0) begin
				n_valid++;
			end
		end
		check_count("issue_count", issue_count, ICNT_W'(n_valid));
		check_full("rs_full", rs_full, row_full[k]);
	endtask

	task automatic drive_row(input int k);
		dispatch    <= row_disp[k];
		dispatch_op <= row_op[k];
		cdb         <= row_cdb[k];
		lsq_block   <= row_lsq[k];
		enable      <= row_en[k];
	endtask

	// ------------------------------------------------------------------------
	// Stimulus table in columns disp fu dest s1 r1 s2 r2 cdb_v cdb_tag ld st en
	// followed by the expected rows alu ld st mult br and the full flag
	// ------------------------------------------------------------------------
	task automatic build_table();
		// Ready ops issue two edges after dispatch
		add_row(1, FU_ALU, 10, 1, 1, 2, 1, 0, 0, 0, 0, 1, -1, -1, -1, -1, -1, 0);
		add_row(0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, -1, -1, -1, -1, 0);
		add_row(1, FU_MULT, 11, 3, 1, 4, 1, 0, 0, 0, 0, 1, -1, -1, -1, -1, -1, 0);
		add_row(1, FU_BR, 12, 5, 1, 6, 1, 0, 0, 0, 0, 1, -1, -1, -1, 2, -1, 0);
		add_row(0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, -1, -1, -1, -1, 3, 0);
		// Sources wake in different bus cycles
		add_row(1, FU_ALU, 13, 20, 0, 21, 0, 0, 0, 0, 0, 1, -1, -1, -1, -1, -1, 0);
		add_row(0, FU_ALU, 0, 0, 0, 0, 0, 1, 20, 0, 0, 1, -1, -1, -1, -1, -1, 0);
		add_row(0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, -1, -1, -1, -1, -1, 0);
		add_row(0, FU_ALU, 0, 0, 0, 0, 0, 1, 21, 0, 0, 1, 5, -1, -1, -1, -1, 0);
		add_row(1, FU_LD, 14, 22, 0, 23, 1, 0, 0, 0, 0, 1, -1, -1, -1, -1, -1, 0);
		add_row(0, FU_ALU, 0, 0, 0, 0, 0, 1, 22, 0, 0, 1, -1, 9, -1, -1, -1, 0);
		// Seven ops on tag 30 in entries 0 to 6
		add_row(1, FU_ALU, 15, 30, 0, 7, 1, 0, 0, 0, 0, 1, -1, -1, -1, -1, -1, 0);
		add_row(1, FU_ALU, 16, 30, 0, 8, 1, 0, 0, 0, 0, 1, -1, -1, -1, -1, -1, 0);
		add_row(1, FU_ALU, 17, 9, 1, 30, 0, 0, 0, 0, 0, 1, -1, -1, -1, -1, -1, 0);
		add_row(1, FU_LD, 18, 30, 0, 10, 1, 0, 0, 0, 0, 1, -1, -1, -1, -1, -1, 0);
		add_row(1, FU_ST, 19, 30, 0, 11, 1, 0, 0, 0, 0, 1, -1, -1, -1, -1, -1, 0);
		add_row(1, FU_MULT, 20, 12, 1, 30, 0, 0, 0, 0, 0, 1, -1, -1, -1, -1, -1, 0);
		add_row(1, FU_BR, 21, 30, 0, 13, 1, 0, 0, 0, 0, 1, -1, -1, -1, -1, -1, 0);
		// All five ports at once and then the lower ALU entries in turn
		add_row(0, FU_ALU, 0, 0, 0, 0, 0, 1, 30, 0, 0, 1, 13, 14, 15, 16, 17, 0);
		add_row(0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 12, -1, -1, -1, -1, 0);
		add_row(0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 11, -1, -1, -1, -1, 0);
		// Load and store held by queue full levels
		add_row(1, FU_LD, 22, 1, 1, 2, 1, 0, 0, 1, 0, 1, -1, -1, -1, -1, -1, 0);
		add_row(1, FU_ST, 23, 3, 1, 4, 1, 0, 0, 1, 1, 1, -1, -1, -1, -1, -1, 0);
		add_row(1, FU_ALU, 24, 5, 1, 6, 1, 0, 0, 1, 1, 1, -1, -1, -1, -1, -1, 0);
		add_row(0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 23, -1, -1, -1, -1, 0);
		add_row(0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, -1, 21, -1, -1, -1, 0);
		add_row(0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, -1, -1, 22, -1, -1, 0);
		// Fill all twelve entries with each waiting on its own tag 40+i
		for (int i = 0; i < RS_SIZE; i++) begin
			add_row(1, FU_ALU, 32 + i, 40 + i, 0, 1, 1, 0, 0, 0, 0, 1,
				-1, -1, -1, -1, -1, i == RS_SIZE - 1);
		end
		// Producer holds off while full and tag 45 frees entry 5
		add_row(0, FU_ALU, 60, 1, 1, 2, 1, 1, 45, 0, 0, 1, 32, -1, -1, -1, -1, 0);
		// Frozen pipe drops the dispatch but tag 40 still wakes entry 0
		add_row(1, FU_ALU, 61, 1, 1, 2, 1, 1, 40, 0, 0, 0, -1, -1, -1, -1, -1, 0);
		add_row(0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, -1, -1, -1, -1, -1, 0);
		add_row(0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 27, -1, -1, -1, -1, 0);
		add_row(0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, -1, -1, -1, -1, -1, 0);
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		reset = 1'b1;
		enable = 1'b1;
		dispatch = 1'b0;
		dispatch_op = '0;
		cdb = '0;
		lsq_block = '0;
		build_table();
		if (row_idx != NUM_ROWS) begin
			stop_run("stimulus table length does not match NUM_ROWS");
		end
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		// Outputs straight out of reset
		for (int c = 0; c < NUM_FU; c++) begin
			check_issue($sformatf("issue_out[%0d] after reset", c), issue_out[c], '0);
		end
		check_count("issue_count", issue_count, '0);
		check_full("rs_full", rs_full, 1'b0);
		// Row k drives cycle k and its results show after the following edge
		for (int k = 0; k <= NUM_ROWS; k++) begin
			@(posedge clock);
			if (k < NUM_ROWS) begin
				drive_row(k);
			end else begin
				dispatch <= 1'b0;
				cdb <= '0;
				lsq_block <= '0;
			end
			@(negedge clock);
			if (k > 0) begin
				check_row(k - 1);
			end
		end
		$display("sim passed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		stop_run("watchdog expired before the stimulus table finished");
	end

endmodule

// File: sim.f
rtl/rs_pkg.sv
rtl/tag_cam.sv
rtl/prio_select.sv
rtl/rs_entry_table.sv
rtl/issue_select.sv
rtl/rs_top.sv
testbench/rs_tb.sv
